//--- verilog/playseq_pkg.sv
// Colour and state enums, move, config and status structs, colour sequence table
`default_nettype none

package playseq_pkg;

    localparam int SEQ_DEPTH = 16;  // Entries per bank
    localparam int SEQ_BANKS = 4;

    typedef enum logic [1:0] {
        green  = 2'd0,
        red    = 2'd1,
        blue   = 2'd2,
        yellow = 2'd3
    } color_t;

    // Codes match the debug display
    typedef enum logic [3:0] {
        idle        = 4'h0,
        prepare     = 4'h1,
        next_round  = 4'h2,
        wait_move   = 4'h3,
        take_move   = 4'h4,
        compare     = 4'h5,
        next_pos    = 4'h6,
        gap_led     = 4'h7,
        end_win     = 4'hA,
        show_led    = 4'hB,
        showed_led  = 4'hC,
        start_round = 4'hD,
        end_error   = 4'hE,
        end_timeout = 4'hF
    } state_t;

    typedef struct packed {
        color_t color;
    } move_t;

    typedef struct packed {
        logic [1:0] level;  // Final length is 4 * level + 4
        logic [1:0] bank;
    } game_cfg_t;

    typedef struct packed {
        logic ready;
        logic won;
        logic lost;
        logic timed_out;
        logic preview;
    } game_status_t;

    // --------------------
    // Sequence table
    // --------------------
    typedef color_t [SEQ_DEPTH-1:0] seq_bank_t;
    typedef seq_bank_t [SEQ_BANKS-1:0] seq_table_t;

    function automatic seq_table_t build_seq_table();
        seq_table_t table_out;
        for (int b = 0; b < SEQ_BANKS; b++) begin
            for (int i = 0; i < SEQ_DEPTH; i++) begin
                table_out[b][i] = color_t'((3 * i + b + i / 2) % 4);
            end
        end
        return table_out;
    endfunction

    localparam seq_table_t SEQ_TABLE = build_seq_table();

endpackage

`default_nettype wire

//--- verilog/sequence_rom.sv
// Colour sequence ROM with registered read, four banks of sixteen entries
`timescale 1ns/1ps
`default_nettype none

module sequence_rom (
    input  wire                 clock,
    input  wire [1:0]           bank,
    input  wire [3:0]           addr,
    output playseq_pkg::color_t color
);
    import playseq_pkg::*;

    // One cycle from address to colour
    always_ff @(posedge clock) begin
        color <= SEQ_TABLE[bank][addr];
    end

    // --------------------
    // Checks
    // --------------------
    // Position counter must never run past a bank
    addr_in_range: assert property (
        @(posedge clock) !$isunknown(addr) |-> (int'(addr) < SEQ_DEPTH)
    );

endmodule

`default_nettype wire

//--- verilog/move_capture.sv
// Four-phase req/ack move receiver with a one-entry hold register
`timescale 1ns/1ps
`default_nettype none

module move_capture (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 move_req,
    input  wire playseq_pkg::move_t move,
    output logic                move_ack,
    input  wire                 take,
    output logic                pending,
    output playseq_pkg::move_t  held
);

    logic accept;

    // New move only when idle on the link and nothing held
    assign accept = move_req && !move_ack && !pending;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            move_ack <= 1'b0;
            pending  <= 1'b0;
        end else begin
            if (accept) begin
                move_ack <= 1'b1;
            end else if (move_ack && !move_req) begin
                move_ack <= 1'b0;  // Phase 4
            end

            if (accept) begin
                pending <= 1'b1;
            end else if (take) begin
                pending <= 1'b0;  // Control unit consumed it
            end
        end
    end

    // Payload only
    always_ff @(posedge clock) begin
        if (accept) begin
            held <= move;
        end
    end

    take_needs_pending: assert property (
        @(posedge clock) disable iff (reset) take |-> pending
    );

    ack_follows_req: assert property (
        @(posedge clock) disable iff (reset) $rose(move_ack) |-> $past(move_req)
    );

endmodule

`default_nettype wire

//--- verilog/playseq_datapath.sv
// Game datapath: position and round counters, config register, LED and move timers, comparator
`timescale 1ns/1ps
`default_nettype none

module playseq_datapath #(
    parameter int LED_CYCLES          = 4,
    parameter int MOVE_TIMEOUT_CYCLES = 30
) (
    input  wire                      clock,
    input  wire                      reset,
    input  wire playseq_pkg::game_cfg_t cfg,
    input  wire                      clear_pos,
    input  wire                      count_pos,
    input  wire                      load_cfg,
    input  wire                      clear_round,
    input  wire                      count_round,
    input  wire                      store_move,
    input  wire                      clear_led_timer,
    input  wire                      count_led_timer,
    input  wire                      clear_move_timer,
    input  wire                      count_move_timer,
    input  wire playseq_pkg::move_t  held,
    input  wire playseq_pkg::color_t rom_color,
    output logic [1:0]               bank,
    output logic [3:0]               addr,
    output logic                     pos_last,
    output logic                     round_last,
    output logic                     match,
    output logic                     led_done,
    output logic                     move_timeout
);
    import playseq_pkg::*;

    localparam int LED_W  = $clog2(LED_CYCLES + 1);
    localparam int MOVE_W = $clog2(MOVE_TIMEOUT_CYCLES + 1);

    game_cfg_t         cfg_reg;
    logic [3:0]        pos;
    logic [4:0]        round_len;  // 1 to 16
    logic [4:0]        final_len;
    color_t            move_reg;
    logic [LED_W-1:0]  led_timer;
    logic [MOVE_W-1:0] move_timer;

    // --------------------
    // Config and counters
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cfg_reg   <= '0;
            pos       <= 4'd0;
            round_len <= 5'd1;
        end else begin
            if (load_cfg) cfg_reg <= cfg;

            if (clear_pos) begin
                pos <= 4'd0;
            end else if (count_pos) begin
                pos <= pos + 4'd1;
            end

            if (clear_round) begin
                round_len <= 5'd1;
            end else if (count_round) begin
                round_len <= round_len + 5'd1;
            end
        end
    end

    assign final_len  = {1'b0, cfg_reg.level, 2'b00} + 5'd4;
    assign pos_last   = ({1'b0, pos} == round_len - 5'd1);
    assign round_last = (round_len == final_len);
    assign bank       = cfg_reg.bank;
    assign addr       = pos;

    // Taken move and comparator
    always_ff @(posedge clock) begin
        if (store_move) move_reg <= held.color;
    end

    assign match = (move_reg == rom_color);

    // --------------------
    // Timers
    // --------------------
    // LED timer wraps at its last count so lit and dark phases chain
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            led_timer  <= '0;
            move_timer <= '0;
        end else begin
            if (clear_led_timer) begin
                led_timer <= '0;
            end else if (count_led_timer) begin
                led_timer <= led_done ? '0 : led_timer + 1'b1;
            end

            if (clear_move_timer) begin
                move_timer <= '0;
            end else if (count_move_timer && !move_timeout) begin
                move_timer <= move_timer + 1'b1;
            end
        end
    end

    assign led_done     = (led_timer == LED_W'(LED_CYCLES - 1));
    assign move_timeout = (move_timer == MOVE_W'(MOVE_TIMEOUT_CYCLES - 1));

    round_len_bounded: assert property (
        @(posedge clock) disable iff (reset) round_len <= final_len
    );

endmodule

`default_nettype wire

//--- verilog/playseq_control.sv
// Moore control unit for preview, player input, compare and game end
`timescale 1ns/1ps
`default_nettype none

module playseq_control (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         play,
    input  wire                         pending,
    input  wire                         pos_last,
    input  wire                         round_last,
    input  wire                         match,
    input  wire                         led_done,
    input  wire                         move_timeout,
    output logic                        clear_pos,
    output logic                        count_pos,
    output logic                        load_cfg,
    output logic                        clear_round,
    output logic                        count_round,
    output logic                        store_move,
    output logic                        clear_led_timer,
    output logic                        count_led_timer,
    output logic                        clear_move_timer,
    output logic                        count_move_timer,
    output logic                        take,
    output logic                        led_on,
    output playseq_pkg::game_status_t   status,
    output playseq_pkg::state_t         db_state
);
    import playseq_pkg::*;

    state_t state;
    state_t state_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            idle:        if (play) state_next = prepare;
            prepare:     state_next = gap_led;  // Dark lead-in, ROM settles
            gap_led:     if (led_done) state_next = show_led;
            show_led: begin
                if (led_done) state_next = pos_last ? start_round : showed_led;
            end
            showed_led:  state_next = gap_led;
            start_round: state_next = wait_move;
            wait_move: begin
                if (pending) begin
                    state_next = take_move;
                end else if (move_timeout) begin
                    state_next = end_timeout;
                end
            end
            take_move:   state_next = compare;
            compare: begin
                if (!match) begin
                    state_next = end_error;
                end else if (!pos_last) begin
                    state_next = next_pos;
                end else begin
                    state_next = round_last ? end_win : next_round;
                end
            end
            next_pos:    state_next = wait_move;
            next_round:  state_next = gap_led;
            end_win, end_error, end_timeout: begin
                if (play) state_next = prepare;
            end
            default:     state_next = idle;
        endcase
    end

    // --------------------
    // Moore outputs
    // --------------------
    always_comb begin
        clear_pos        = (state == idle) || (state == prepare) || (state == start_round)
                           || (state == next_round);
        count_pos        = (state == showed_led) || (state == next_pos);
        load_cfg         = (state == prepare);
        clear_round      = (state == idle) || (state == prepare);
        count_round      = (state == next_round);
        store_move       = (state == take_move);
        take             = (state == take_move);
        clear_led_timer  = (state == prepare) || (state == next_round);
        count_led_timer  = (state == gap_led) || (state == show_led) || (state == showed_led);
        clear_move_timer = (state == start_round) || (state == next_pos);
        count_move_timer = (state == wait_move);
        led_on           = (state == show_led);

        status.ready     = (state == end_win) || (state == end_error) || (state == end_timeout);
        status.won       = (state == end_win);
        status.lost      = (state == end_error) || (state == end_timeout);
        status.timed_out = (state == end_timeout);
        status.preview   = (state == gap_led) || (state == show_led) || (state == showed_led);
    end

    assign db_state = state;

    won_lost_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(status.won && status.lost)
    );

endmodule

`default_nettype wire

//--- verilog/playseq_top.sv
// Sequence game top level: move capture, sequence ROM, datapath, control unit, LED decode
`timescale 1ns/1ps
`default_nettype none

module playseq_top #(
    parameter int LED_CYCLES          = 4,
    parameter int MOVE_TIMEOUT_CYCLES = 30
) (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         play,
    input  wire playseq_pkg::game_cfg_t cfg,
    input  wire                         move_req,
    input  wire playseq_pkg::move_t     move,
    output logic                        move_ack,
    output logic [3:0]                  leds,
    output playseq_pkg::game_status_t   status,
    output playseq_pkg::state_t         db_state
);
    import playseq_pkg::*;

    move_t      held;
    color_t     rom_color;
    logic [1:0] bank;
    logic [3:0] addr;
    logic       pending, take, led_on;
    logic       pos_last, round_last, match, led_done, move_timeout;
    logic       clear_pos, count_pos, load_cfg, clear_round, count_round;
    logic       store_move, clear_led_timer, count_led_timer;
    logic       clear_move_timer, count_move_timer;

    move_capture u_move_capture (.*);  // Producer side

    sequence_rom u_sequence_rom (
        .clock (clock),
        .bank  (bank),
        .addr  (addr),
        .color (rom_color)
    );

    playseq_datapath #(
        .LED_CYCLES          (LED_CYCLES),
        .MOVE_TIMEOUT_CYCLES (MOVE_TIMEOUT_CYCLES)
    ) u_datapath (.*);

    playseq_control u_control (.*);

    // One-hot LEDs, all off when dark
    always_comb begin
        leds = 4'b0000;
        if (led_on) leds[rom_color] = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/playseq_tb.sv
// Sequence game testbench: stimulus table, player model, preview checks and result checks
`timescale 1ns/1ps
`default_nettype none

module playseq_tb;
    import playseq_pkg::*;

    localparam int LED_CYCLES          = 2;
    localparam int MOVE_TIMEOUT_CYCLES = 20;
    localparam int NUM_ROWS            = 7;
    // Worst game is level 3, rounds of 1 to 16 colours, 136 colours in all
    localparam int GAME_CYCLES = 136 * (2 * LED_CYCLES + 14) + 16 * (MOVE_TIMEOUT_CYCLES + 12);
    localparam int CYCLE_LIMIT = NUM_ROWS * GAME_CYCLES + 200;

    // Field order is ready, won, lost, timed_out, preview
    localparam game_status_t END_WIN     = game_status_t'(5'b11000);
    localparam game_status_t END_ERROR   = game_status_t'(5'b10100);
    localparam game_status_t END_TIMEOUT = game_status_t'(5'b10110);

    typedef enum logic [1:0] {correct, wrong, silent, early} kind_t;

    typedef struct packed {
        logic [1:0]   level;
        logic [1:0]   bank;
        kind_t        kind;
        logic [4:0]   fault_round;  // 0 means no fault
        logic [3:0]   fault_pos;
        game_status_t exp_end;
    } row_t;

    logic         clock;
    logic         reset;
    logic         play;
    game_cfg_t    cfg;
    logic         move_req;
    move_t        move;
    logic         move_ack;
    logic [3:0]   leds;
    game_status_t status;
    state_t       db_state;

    row_t       rows [NUM_ROWS];
    color_t     shown [$];  // Colours seen in one preview
    logic [7:0] lfsr;
    int         cycle_count;
    int         checks;
    int         errors;
    int         game_errors;

    playseq_top #(
        .LED_CYCLES          (LED_CYCLES),
        .MOVE_TIMEOUT_CYCLES (MOVE_TIMEOUT_CYCLES)
    ) u_playseq_top (
        .clock    (clock),
        .reset    (reset),
        .play     (play),
        .cfg      (cfg),
        .move_req (move_req),
        .move     (move),
        .move_ack (move_ack),
        .leds     (leds),
        .status   (status),
        .db_state (db_state)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Hang guard
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

    // --------------------
    // Helpers
    // --------------------
    // Fibonacci LFSR x^8 + x^6 + x^5 + x^4 + 1, one step per bit
    function automatic int lfsr_bits(input int n);
        int   bits;
        logic fb;
        bits = 0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
            lfsr = {lfsr[6:0], fb};
            bits = (bits << 1) | int'(fb);
        end
        return bits;
    endfunction

    // Entry i of bank b is (3i + b + i/2) mod 4
    function automatic color_t seq_color(input logic [1:0] bank, input int i);
        return color_t'(2'((3 * i + int'(bank) + i / 2) % 4));
    endfunction

    function automatic color_t led_color(input logic [3:0] lit);
        color_t c;
        c = green;
        for (int b = 0; b < 4; b++) begin
            if (lit[b]) c = color_t'(2'(b));
        end
        return c;
    endfunction

    task automatic step();
        @(posedge clock);
        #5;
    endtask

    task automatic log_fail(input string msg);
        errors++;
        game_errors++;
        $display("%s", msg);
    endtask

    task automatic check_color(input string name, input color_t got, input color_t expected);
        checks++;
        if (got !== expected) begin
            log_fail($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_status(input string name, input game_status_t got,
                                input game_status_t expected);
        checks++;
        if (got !== expected) begin
            log_fail($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_state(input string name, input state_t got, input state_t expected);
        checks++;
        if (got !== expected) begin
            log_fail($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_bits(input string name, input logic [3:0] got, input logic [3:0] expected);
        checks++;
        if (got !== expected) begin
            log_fail($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
        end
    endtask

    // --------------------
    // Player model
    // --------------------
    task automatic send_move(input color_t c);
        move     = '{color: c};
        move_req = 1'b1;
        while (!move_ack) step();
        move_req = 1'b0;  // Phase 3
        while (move_ack) step();
    endtask

    // Two moves during the preview, the second must wait for the take
    task automatic early_moves(input logic [1:0] bank);
        while (!status.preview) step();
        send_move(seq_color(bank, 0));
        move     = '{color: seq_color(bank, 1)};
        move_req = 1'b1;
        while (!move_ack) step();
        checks++;
        if (status.preview) log_fail("Second move was acknowledged while the preview was running");
        move_req = 1'b0;
        while (move_ack) step();
    endtask

    task automatic collect_preview();
        logic [3:0] last;
        last = 4'b0000;
        shown.delete();
        while (!status.preview) step();
        while (status.preview) begin
            if (leds != 4'b0000 && last == 4'b0000) begin
                checks++;
                if (!$onehot(leds)) begin
                    log_fail($sformatf("[FAIL] leds got %h expected one-hot", leds));
                end
                shown.push_back(led_color(leds));
            end
            last = leds;
            step();
        end
    endtask

    task automatic check_preview(input int n, input logic [1:0] bank);
        checks++;
        if (shown.size() != n) begin
            log_fail($sformatf("Round %0d preview showed %0d colours instead of %0d",
                               n, shown.size(), n));
        end else begin
            for (int i = 0; i < n; i++) begin
                check_color($sformatf("leds round %0d pos %0d", n, i), shown[i],
                            seq_color(bank, i));
            end
        end
    endtask

    task automatic play_game(input row_t r);
        int     final_len;
        color_t c;
        bit     done;
        final_len = 4 * int'(r.level) + 4;
        done      = 1'b0;
        cfg       = '{level: r.level, bank: r.bank};
        play      = 1'b1;
        step();
        play = 1'b0;
        for (int n = 1; n <= final_len && !done; n++) begin
            int first_pos;
            first_pos = 0;
            if (r.kind == early && n == int'(r.fault_round)) begin
                fork
                    collect_preview();
                    early_moves(r.bank);
                join
                first_pos = 2;
            end else begin
                collect_preview();
            end
            check_preview(n, r.bank);
            for (int p = first_pos; p < n && !done; p++) begin
                c = seq_color(r.bank, p);
                if (n == int'(r.fault_round) && p == int'(r.fault_pos) && r.kind == wrong) begin
                    send_move(color_t'(~c));  // Any other colour
                    done = 1'b1;
                end else if (n == int'(r.fault_round) && p == int'(r.fault_pos)
                             && r.kind == silent) begin
                    done = 1'b1;
                end else begin
                    send_move(c);
                end
            end
        end
        while (!status.ready) step();
        check_status("status", status, r.exp_end);
        check_bits("leds", leds, 4'b0000);
        repeat (4 * LED_CYCLES) step();  // Result holds, no new preview
        check_status("status", status, r.exp_end);
    endtask

    task automatic build_rows();
        logic [1:0] bank_a;
        logic [1:0] bank_b;
        logic [1:0] bank_c;
        logic [3:0] pos_a;
        logic [3:0] pos_b;
        bank_a = 2'(lfsr_bits(2));
        bank_b = 2'(lfsr_bits(2));
        bank_c = 2'(lfsr_bits(2));
        pos_a  = 4'(lfsr_bits(4) % 3);
        pos_b  = 4'(lfsr_bits(4) % 4);
        rows[0] = '{2'd0, 2'd0,   correct, 5'd0, 4'd0,  END_WIN};
        rows[1] = '{2'd1, bank_a, wrong,   5'd3, pos_a, END_ERROR};
        rows[2] = '{2'd0, 2'd2,   silent,  5'd2, 4'd1,  END_TIMEOUT};
        rows[3] = '{2'd1, 2'd3,   early,   5'd5, 4'd0,  END_WIN};
        rows[4] = '{2'd0, bank_b, wrong,   5'd4, pos_b, END_ERROR};  // Fault in final round
        rows[5] = '{2'd3, 2'd1,   correct, 5'd0, 4'd0,  END_WIN};
        rows[6] = '{2'd2, bank_c, silent,  5'd1, 4'd0,  END_TIMEOUT};
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        kind_t kind_now;
        reset       = 1'b1;
        play        = 1'b0;
        cfg         = '0;
        move_req    = 1'b0;
        move        = '0;
        lfsr        = 8'd46;
        checks      = 0;
        errors      = 0;
        game_errors = 0;
        build_rows();
        repeat (4) @(posedge clock);
        #5;
        reset = 1'b0;

        check_bits("leds", leds, 4'b0000);
        check_bits("move_ack", {3'b000, move_ack}, 4'b0000);
        check_status("status", status, '0);
        check_state("db_state", db_state, idle);
        $display("reset: %s", game_errors == 0 ? "ok" : "mismatch");

        for (int g = 0; g < NUM_ROWS; g++) begin
            game_errors = 0;
            kind_now    = rows[g].kind;
            play_game(rows[g]);
            $display("game %0d level %0d bank %0d %s: %s", g, rows[g].level, rows[g].bank,
                     kind_now.name(), game_errors == 0 ? "ok" : "mismatch");
        end

        $display("%0d games, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/playseq_pkg.sv
verilog/sequence_rom.sv
verilog/move_capture.sv
verilog/playseq_datapath.sv
verilog/playseq_control.sv
verilog/playseq_top.sv
verification/playseq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run, pass only when the testbench reports it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module playseq_tb -f flist.f -o playseq_sim &&
./obj_dir/playseq_sim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null &&
echo "Simulation result: PASS" ||
{ echo "Simulation result: FAIL"; exit 1; }
